// File: hw/attn_pkg.sv
// Attention element package with shared widths, sizes and FSM state types
`default_nettype none

package attn_pkg;

    // Vector shape
    localparam int EMBED_DIM  = 4;   // Elements per q, k and v vector
    localparam int ELEM_W     = 8;   // q and k signed, v unsigned
    localparam int MAX_KEYS   = 64;  // Longest key run for one query
    localparam int KEY_CNT_W  = $clog2(MAX_KEYS);

    // Dot-product score, full precision for EMBED_DIM signed products
    localparam int SCORE_W    = 2 * ELEM_W + $clog2(EMBED_DIM);

    // Base-2 weights in Q1.15
    localparam int WEIGHT_FRAC = 15;
    localparam int WEIGHT_W    = WEIGHT_FRAC + 1;
    localparam int WEIGHT_ONE  = 1 << WEIGHT_FRAC;  // 1.0
    localparam int SHIFT_CAP   = 16;                // Weight is zero at this shift
    localparam int SHIFT_W     = $clog2(SHIFT_CAP + 1);

    // Accumulators sized so MAX_KEYS full-weight terms never overflow
    localparam int ACC_W = ELEM_W + WEIGHT_FRAC + KEY_CNT_W + 1;
    localparam int SUM_W = WEIGHT_W + KEY_CNT_W;

    // Score FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Output divider, one quotient bit per cycle
    localparam int QBIT_W     = $clog2(ELEM_W);
    localparam int ELEM_IDX_W = $clog2(EMBED_DIM);
    localparam int DIV_STEPS  = EMBED_DIM * ELEM_W;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS + 1);

    typedef enum logic [1:0] {
        ACC_IDLE,     // Waiting for the first key of a query
        ACC_RUN,      // Folding in later keys
        ACC_HANDOFF   // Sums held for the divider
    } accum_state_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

// File: hw/score_unit.sv
// Score unit, one register stage computing the q.k score and passing v and last along
`default_nettype none

module score_unit import attn_pkg::*; (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // Input beat
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      in_q,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      in_k,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      in_v,
    input  logic                                  in_last,

    // Toward the score FIFO
    output logic                                  sc_valid,
    input  logic                                  sc_ready,
    output logic signed [SCORE_W-1:0]             sc_score,
    output logic [EMBED_DIM-1:0][ELEM_W-1:0]      sc_v,
    output logic                                  sc_last
);

    logic                      run_en;            // Set one cycle after reset release
    logic                      load;
    logic signed [SCORE_W-1:0] prod [EMBED_DIM];
    logic signed [SCORE_W-1:0] score_sum;

    // Stage is free when empty or when its beat leaves this cycle
    assign in_ready = run_en && (!sc_valid || sc_ready);
    assign load     = in_valid && in_ready;

    // Signed products sign-extended to the score width before summing
    always_comb begin
        score_sum = '0;
        for (int j = 0; j < EMBED_DIM; j++) begin
            prod[j]   = $signed(in_q[j]) * $signed(in_k[j]);
            score_sum = score_sum + prod[j];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_en   <= 1'b0;
            sc_valid <= 1'b0;
        end else begin
            run_en <= 1'b1;
            if (load) begin
                sc_valid <= 1'b1;
            end else if (sc_ready) begin
                sc_valid <= 1'b0;  // Held beat taken, nothing behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sc_score <= score_sum;
            sc_v     <= in_v;
            sc_last  <= in_last;
        end
    end

endmodule

`default_nettype wire

// File: hw/score_fifo.sv
// Score FIFO, a small circular buffer between scoring and accumulation
`default_nettype none

module score_fifo import attn_pkg::*; (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // Write side
    input  logic                                  sc_valid,
    output logic                                  sc_ready,
    input  logic signed [SCORE_W-1:0]             sc_score,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      sc_v,
    input  logic                                  sc_last,

    // Read side
    output logic                                  fq_valid,
    input  logic                                  fq_ready,
    output logic signed [SCORE_W-1:0]             fq_score,
    output logic [EMBED_DIM-1:0][ELEM_W-1:0]      fq_v,
    output logic                                  fq_last
);

    logic signed [SCORE_W-1:0]        score_mem [FIFO_DEPTH];
    logic [EMBED_DIM-1:0][ELEM_W-1:0] v_mem     [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0]            last_mem;

    logic                  run_en;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign sc_ready = run_en && (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign fq_valid = (count != '0);
    assign wr_en    = sc_valid && sc_ready;
    assign rd_en    = fq_valid && fq_ready;

    assign fq_score = score_mem[rd_ptr];
    assign fq_v     = v_mem[rd_ptr];
    assign fq_last  = last_mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_en <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            run_en <= 1'b1;
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Power-of-two depth wraps naturally
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            score_mem[wr_ptr] <= sc_score;
            v_mem[wr_ptr]     <= sc_v;
            last_mem[wr_ptr]  <= sc_last;
        end
    end

endmodule

`default_nettype wire

// File: hw/softmax_accum.sv
// Softmax accumulator, online maximum with base-2 weighted sums of values and weights
`default_nettype none

module softmax_accum import attn_pkg::*; (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // From the score FIFO
    input  logic                                  fq_valid,
    output logic                                  fq_ready,
    input  logic signed [SCORE_W-1:0]             fq_score,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      fq_v,
    input  logic                                  fq_last,

    // Toward the divider
    output logic                                  acc_valid,
    input  logic                                  acc_ready,
    output logic [EMBED_DIM-1:0][ACC_W-1:0]       acc_vec,
    output logic [SUM_W-1:0]                      acc_sum
);

    accum_state_t state;

    logic signed [SCORE_W-1:0]       m_r;   // Running maximum score
    logic [SUM_W-1:0]                l_r;   // Weight sum
    logic [EMBED_DIM-1:0][ACC_W-1:0] o_r;   // Weighted value sums

    logic                        take;
    logic                        first;
    logic                        rising;
    logic signed [SCORE_W:0]     diff;
    logic [SCORE_W:0]            mag;
    logic [SHIFT_W-1:0]          sh;
    logic [WEIGHT_W-1:0]         w_new;
    logic signed [SCORE_W-1:0]   m_nxt;
    logic [SUM_W-1:0]            l_base;
    logic [SUM_W-1:0]            l_nxt;
    logic [EMBED_DIM-1:0][ACC_W-1:0] o_base;
    logic [EMBED_DIM-1:0][ACC_W-1:0] o_nxt;

    assign fq_ready  = (state != ACC_HANDOFF);
    assign acc_valid = (state == ACC_HANDOFF);
    assign acc_vec   = o_r;
    assign acc_sum   = l_r;
    assign take      = fq_valid && fq_ready;
    assign first     = (state == ACC_IDLE);

    // Distance of the new score from the running max, capped at SHIFT_CAP
    assign diff   = SCORE_W'(fq_score) - SCORE_W'(m_r);
    assign rising = (diff > 0);
    assign mag    = rising ? diff : -diff;
    assign sh     = (mag > SHIFT_CAP) ? SHIFT_W'(SHIFT_CAP) : mag[SHIFT_W-1:0];

    always_comb begin
        if (first || rising) begin
            w_new = WEIGHT_W'(WEIGHT_ONE);   // New entry is the max, full weight
            m_nxt = fq_score;
        end else begin
            w_new = WEIGHT_W'(WEIGHT_ONE) >> sh;
            m_nxt = m_r;
        end

        // Older terms drop out on a new query, rescale on a new max
        if (first) begin
            l_base = '0;
            o_base = '0;
        end else if (rising) begin
            l_base = l_r >> sh;
            for (int j = 0; j < EMBED_DIM; j++) o_base[j] = o_r[j] >> sh;
        end else begin
            l_base = l_r;
            o_base = o_r;
        end

        l_nxt = l_base + SUM_W'(w_new);
        for (int j = 0; j < EMBED_DIM; j++) begin
            o_nxt[j] = o_base[j] + ACC_W'(fq_v[j]) * ACC_W'(w_new);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ACC_IDLE;
        end else begin
            case (state)
                ACC_IDLE, ACC_RUN: begin
                    if (take) state <= fq_last ? ACC_HANDOFF : ACC_RUN;
                end
                ACC_HANDOFF: begin
                    if (acc_ready) state <= ACC_IDLE;  // Divider has the sums
                end
                default: state <= ACC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_r <= m_nxt;
            l_r <= l_nxt;
            o_r <= o_nxt;
        end
    end

endmodule

`default_nettype wire

// File: hw/vector_divider.sv
// Output divider, restoring division of each value sum by the weight sum
`default_nettype none

module vector_divider import attn_pkg::*; (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // From the accumulator
    input  logic                                  acc_valid,
    output logic                                  acc_ready,
    input  logic [EMBED_DIM-1:0][ACC_W-1:0]       acc_vec,
    input  logic [SUM_W-1:0]                      acc_sum,

    // Normalized output
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [EMBED_DIM-1:0][ELEM_W-1:0]      out_vec
);

    div_state_t state;

    logic [DIV_CNT_W-1:0]            cnt;     // Elem index in upper bits, bit step in lower
    logic [EMBED_DIM-1:0][ACC_W-1:0] num_r;
    logic [SUM_W-1:0]                den_r;
    logic [ACC_W-1:0]                rem_r;
    logic [EMBED_DIM-1:0][ELEM_W-1:0] quot_r;

    logic                  commit;
    logic [ELEM_IDX_W-1:0] elem_idx;
    logic [QBIT_W-1:0]     bit_idx;
    logic [ACC_W-1:0]      rem_cur;
    logic [ACC_W-1:0]      trial;
    logic [ACC_W:0]        diff;

    assign acc_ready = (state == DIV_IDLE);
    assign out_valid = (state == DIV_DONE);
    assign commit    = (cnt == DIV_CNT_W'(DIV_STEPS));

    // Quotient is a weighted mean of 8-bit values, so eight bits MSB first suffice
    assign elem_idx = cnt[QBIT_W +: ELEM_IDX_W];
    assign bit_idx  = QBIT_W'(ELEM_W - 1) - cnt[QBIT_W-1:0];
    assign rem_cur  = (cnt[QBIT_W-1:0] == '0) ? num_r[elem_idx] : rem_r;
    assign trial    = ACC_W'(den_r) << bit_idx;
    assign diff     = {1'b0, rem_cur} - {1'b0, trial};  // MSB set means restore

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: if (acc_valid) begin
                    state <= DIV_RUN;
                    cnt   <= '0;
                end
                DIV_RUN: begin
                    if (commit) state <= DIV_DONE;
                    else        cnt   <= cnt + 1'b1;
                end
                DIV_DONE: if (out_ready) state <= DIV_IDLE;
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid && acc_ready) begin
            num_r <= acc_vec;
            den_r <= acc_sum;
        end
        if (state == DIV_RUN) begin
            if (commit) begin
                out_vec <= quot_r;   // Extra step publishes all elements at once
            end else begin
                rem_r                     <= diff[ACC_W] ? rem_cur : diff[ACC_W-1:0];
                quot_r[elem_idx][bit_idx] <= ~diff[ACC_W];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/attention_pe.sv
// Attention PE top, score unit feeding a FIFO, softmax accumulator and output divider
`default_nettype none

module attention_pe import attn_pkg::*; (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // Key/value stream with the query on every beat
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      in_q,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      in_k,
    input  logic [EMBED_DIM-1:0][ELEM_W-1:0]      in_v,
    input  logic                                  in_last,

    // One output vector per query
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [EMBED_DIM-1:0][ELEM_W-1:0]      out_vec
);

    // Score unit to FIFO
    logic                             sc_valid;
    logic                             sc_ready;
    logic signed [SCORE_W-1:0]        sc_score;
    logic [EMBED_DIM-1:0][ELEM_W-1:0] sc_v;
    logic                             sc_last;

    // FIFO to accumulator
    logic                             fq_valid;
    logic                             fq_ready;
    logic signed [SCORE_W-1:0]        fq_score;
    logic [EMBED_DIM-1:0][ELEM_W-1:0] fq_v;
    logic                             fq_last;

    // Accumulator to divider
    logic                             acc_valid;
    logic                             acc_ready;
    logic [EMBED_DIM-1:0][ACC_W-1:0]  acc_vec;
    logic [SUM_W-1:0]                 acc_sum;

    score_unit u_score_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_q     (in_q),
        .in_k     (in_k),
        .in_v     (in_v),
        .in_last  (in_last),
        .sc_valid (sc_valid),
        .sc_ready (sc_ready),
        .sc_score (sc_score),
        .sc_v     (sc_v),
        .sc_last  (sc_last)
    );

    score_fifo u_score_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .sc_valid (sc_valid),
        .sc_ready (sc_ready),
        .sc_score (sc_score),
        .sc_v     (sc_v),
        .sc_last  (sc_last),
        .fq_valid (fq_valid),
        .fq_ready (fq_ready),
        .fq_score (fq_score),
        .fq_v     (fq_v),
        .fq_last  (fq_last)
    );

    softmax_accum u_softmax_accum (
        .clk       (clk),
        .arst_n    (arst_n),
        .fq_valid  (fq_valid),
        .fq_ready  (fq_ready),
        .fq_score  (fq_score),
        .fq_v      (fq_v),
        .fq_last   (fq_last),
        .acc_valid (acc_valid),
        .acc_ready (acc_ready),
        .acc_vec   (acc_vec),
        .acc_sum   (acc_sum)
    );

    vector_divider u_vector_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc_ready (acc_ready),
        .acc_vec   (acc_vec),
        .acc_sum   (acc_sum),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_vec   (out_vec)
    );

endmodule

`default_nettype wire

// File: test/attention_pe_asserts.sv
// Handshake assertions for the attention PE, bound to its top level
`default_nettype none

module attention_pe_asserts import attn_pkg::*; (
    input logic                             clk,
    input logic                             arst_n,
    input logic                             in_valid,
    input logic                             in_ready,
    input logic [EMBED_DIM-1:0][ELEM_W-1:0] in_q,
    input logic [EMBED_DIM-1:0][ELEM_W-1:0] in_k,
    input logic [EMBED_DIM-1:0][ELEM_W-1:0] in_v,
    input logic                             in_last,
    input logic                             out_valid,
    input logic                             out_ready,
    input logic [EMBED_DIM-1:0][ELEM_W-1:0] out_vec
);

    // Input beat held until taken
    assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_q) && $stable(in_k)
                                  && $stable(in_v) && $stable(in_last))
        else $error("Input beat changed before it was accepted");

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before out_ready");

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_vec))
        else $error("out_vec changed while the output was stalled");

    assert property (@(posedge clk) !arst_n || $rose(arst_n) |-> !out_valid)
        else $error("out_valid high in or right after reset");

endmodule

bind attention_pe attention_pe_asserts u_attention_pe_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_q      (in_q),
    .in_k      (in_k),
    .in_v      (in_v),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_vec   (out_vec)
);

`default_nettype wire

// File: test/tb_attention_pe.sv
// Attention PE testbench with LFSR key/value streams checked against a reference model
`default_nettype none

module tb_attention_pe import attn_pkg::*; ();

    typedef logic [EMBED_DIM-1:0][ELEM_W-1:0] vec_t;

    localparam int     CLK_PERIOD   = 4;
    localparam int     RESET_CYCLES = 8;
    localparam int     QUERY_KEYS   = 8;     // Longest query the stimulus builds
    localparam int     DIV_CYCLES   = 33;
    localparam int     STALL_MARGIN = 120;   // Input gaps plus out_ready stalls
    localparam int     N_SINGLE     = 4;
    localparam int     N_EQUAL      = 4;
    localparam int     N_RISING     = 3;
    localparam int     N_RANDOM     = 24;    // Second half with output stalls
    localparam int     NUM_QUERIES  = N_SINGLE + N_EQUAL + N_RISING + N_RANDOM;
    localparam int     DRAIN_CYCLES = 2 * (FIFO_DEPTH + 3) * (DIV_CYCLES + 2);
    localparam longint W_ONE        = longint'(1) << WEIGHT_FRAC;
    localparam longint WATCHDOG_TIME = longint'(RESET_CYCLES + NUM_QUERIES *
                                       (QUERY_KEYS + DIV_CYCLES + STALL_MARGIN)) * CLK_PERIOD;

    logic clk;
    logic arst_n;
    logic in_valid;
    logic in_ready;
    vec_t in_q;
    vec_t in_k;
    vec_t in_v;
    logic in_last;
    logic out_valid;
    logic out_ready;
    vec_t out_vec;

    vec_t        qry_q;
    vec_t        qry_k [QUERY_KEYS];
    vec_t        qry_v [QUERY_KEYS];
    vec_t        exp_q [$];
    logic [31:0] lfsr_state [2];         // Stream 0 for stimulus and 1 for stalls
    int          n_sent    = 0;
    int          n_out     = 0;
    logic        gaps_en   = 1'b0;
    logic        stall_en  = 1'b0;

    // Scores ride on the first k element and rise with jumps beyond SHIFT_CAP
    int rise_scores [N_RISING][QUERY_KEYS] = '{'{-100, -95, -70, -69, 0, 50, 45, 120},
                                               '{10, 20, 30, 31, 32, 0, 0, 0},
                                               '{5, 4, 30, 29, 13, 90, 0, 0}};
    int rise_len [N_RISING] = '{8, 5, 6};

    attention_pe u_attention_pe (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_q      (in_q),
        .in_k      (in_k),
        .in_v      (in_v),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_vec   (out_vec)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_vec(input string name, input vec_t got, input vec_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw(input int stream, input int nbits);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state[stream] = lfsr_next(lfsr_state[stream]);
            val = {val[30:0], lfsr_state[stream][0]};
        end
        return val;
    endfunction

    function automatic vec_t rand_byte_vec();
        vec_t v;
        for (int j = 0; j < EMBED_DIM; j++) v[j] = ELEM_W'(draw(0, ELEM_W));
        return v;
    endfunction

    // Signed 4-bit elements keep score gaps near the shift cap
    function automatic vec_t rand_small_vec();
        vec_t       v;
        logic [3:0] b;
        for (int j = 0; j < EMBED_DIM; j++) begin
            b    = 4'(draw(0, 4));
            v[j] = {{4{b[3]}}, b};
        end
        return v;
    endfunction

    function automatic vec_t mean_vec(input int n);
        vec_t   res;
        longint sum;
        for (int j = 0; j < EMBED_DIM; j++) begin
            sum = 0;
            for (int i = 0; i < n; i++) sum = sum + longint'(qry_v[i][j]);
            res[j] = ELEM_W'(sum / n);
        end
        return res;
    endfunction

    // Online softmax with base-2 weights over the stored query
    function automatic vec_t ref_output(input int n);
        longint s;
        longint m;
        longint l;
        longint sh;
        longint w;
        longint o [EMBED_DIM];
        vec_t   res;
        m = 0;
        l = 0;
        for (int i = 0; i < n; i++) begin
            s = 0;
            for (int j = 0; j < EMBED_DIM; j++) begin
                s = s + longint'($signed(qry_q[j])) * longint'($signed(qry_k[i][j]));
            end
            if (i == 0) begin
                l = 0;
                for (int j = 0; j < EMBED_DIM; j++) o[j] = 0;
                w = W_ONE;
                m = s;
            end else if (s > m) begin
                sh = (s - m > SHIFT_CAP) ? SHIFT_CAP : s - m;
                l  = l >> sh;   // Older terms rescaled to the new max
                for (int j = 0; j < EMBED_DIM; j++) o[j] = o[j] >> sh;
                w = W_ONE;
                m = s;
            end else begin
                sh = (m - s > SHIFT_CAP) ? SHIFT_CAP : m - s;
                w  = W_ONE >> sh;
            end
            l = l + w;
            for (int j = 0; j < EMBED_DIM; j++) o[j] = o[j] + longint'(qry_v[i][j]) * w;
        end
        for (int j = 0; j < EMBED_DIM; j++) res[j] = ELEM_W'(o[j] / l);
        return res;
    endfunction

    task automatic send_query(input int n, input vec_t exp);
        logic [31:0] gap;
        for (int i = 0; i < n; i++) begin
            in_valid = 1'b1;
            in_q     = qry_q;
            in_k     = qry_k[i];
            in_v     = qry_v[i];
            in_last  = (i == n - 1);
            while (!in_ready) @(negedge clk);
            @(negedge clk);   // Beat taken on the rising edge just passed
            gap = gaps_en ? draw(0, 2) : 32'd0;
            if (gap != 0) begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
        end
        in_valid = 1'b0;
        exp_q.push_back(exp);
        n_sent++;
    endtask

    initial begin : drive_stimulus
        int n;
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_q          = '0;
        in_k          = '0;
        in_v          = '0;
        in_last       = 1'b0;
        lfsr_state[0] = 32'd73543;
        lfsr_state[1] = draw(0, 32);   // Stall stream seeded from the main one
        repeat (RESET_CYCLES) @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b0);
        arst_n = 1'b1;
        for (int c = 0; c < 4 && !in_ready; c++) @(negedge clk);
        if (!in_ready) abort_run("in_ready did not rise within 4 cycles of reset release");
        check_flag("out_valid", out_valid, 1'b0);

        for (int t = 0; t < N_SINGLE; t++) begin
            qry_q    = rand_byte_vec();
            qry_k[0] = rand_byte_vec();
            qry_v[0] = rand_byte_vec();
            send_query(1, qry_v[0]);   // Weight 1.0 passes v through
        end

        for (int t = 0; t < N_EQUAL; t++) begin
            n        = 2 + 2 * int'(draw(0, 2));
            qry_q    = rand_byte_vec();
            qry_k[0] = rand_byte_vec();
            for (int i = 0; i < n; i++) begin
                qry_k[i] = qry_k[0];
                qry_v[i] = rand_byte_vec();
            end
            send_query(n, mean_vec(n));
        end

        qry_q    = '0;
        qry_q[0] = 8'd1;
        for (int t = 0; t < N_RISING; t++) begin
            for (int i = 0; i < rise_len[t]; i++) begin
                qry_k[i]    = '0;
                qry_k[i][0] = ELEM_W'(rise_scores[t][i]);
                qry_v[i]    = rand_byte_vec();
            end
            send_query(rise_len[t], ref_output(rise_len[t]));
        end

        gaps_en = 1'b1;
        for (int t = 0; t < N_RANDOM; t++) begin
            stall_en = (t >= N_RANDOM / 2);
            n        = 1 + int'(draw(0, 3));
            qry_q    = rand_small_vec();
            for (int i = 0; i < n; i++) begin
                qry_k[i] = rand_small_vec();
                qry_v[i] = rand_byte_vec();
            end
            send_query(n, ref_output(n));
        end

        stall_en = 1'b0;
        for (int c = 0; c < DRAIN_CYCLES && n_out < n_sent; c++) @(negedge clk);
        repeat (2 * DIV_CYCLES) @(negedge clk);   // A duplicate output would show up here
        check_count("output count", n_out, n_sent);
        check_flag("out_valid", out_valid, 1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Picks out_ready and checks the vector leaving on the next rising edge
    initial begin : compare_outputs
        vec_t exp;
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                out_ready = stall_en ? (draw(1, 2) != 0) : 1'b1;
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        abort_run("out_valid rose with no query outstanding");
                    end else begin
                        exp = exp_q.pop_front();
                        check_vec("out_vec", out_vec, exp);
                        n_out++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        abort_run($sformatf("Timeout after %0d time units, %0d of %0d outputs seen",
                            WATCHDOG_TIME, n_out, NUM_QUERIES));
    end

endmodule

`default_nettype wire

// File: compile.f
hw/attn_pkg.sv
hw/score_unit.sv
hw/score_fifo.sv
hw/softmax_accum.sv
hw/vector_divider.sv
hw/attention_pe.sv
test/attention_pe_asserts.sv
test/tb_attention_pe.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_attention_pe
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
